/* tb/busTrace.txt */
# op (0 read, 1 write), address, size code (1..3 bytes, 0 long), write data,
# port DSACK code (0 32-bit, 1 16-bit, 2 8-bit), wait cycles (decimal), expected response
0 00000040 0 00000000 0 0 1a1b1819
0 00000045 0 00000000 0 2 1f1c1d12
0 00000051 3 00000000 1 1 000b0809
0 00000063 2 00000000 2 0 0000393e
0 0000006a 1 00000000 1 3 00000030
0 00000072 0 00000000 1 1 28292e2f
1 00000081 0 a1b2c3d4 0 1 00000000
0 00000081 0 00000000 2 0 a1b2c3d4
1 00000093 3 00e5f607 1 2 00000000
0 00000092 0 00000000 0 0 c8e5f607
1 000000a2 2 00001357 2 1 00000000
0 000000a1 3 00000000 1 2 00fb1357
1 000000b7 1 0000009c 0 0 00000000
0 000000b6 2 00000000 0 1 0000ec9c
1 000000c3 0 0badf00d 1 0 00000000
0 000000c2 0 00000000 2 1 980badf0

/* project.f */
design/busPkg.sv
design/busRequestStage.sv
design/busCycleSequencer.sv
design/readLaneAssembler.sv
design/writeLaneDriver.sv
design/bus68020Top.sv
tb/busTb.sv

/* tb/busTb.sv */
// Testbench for the 68020-style bus master
// Trace driven operands against a sized slave port with a byte memory
module busTb;

    logic          CLK;
    logic          in_RESET;
    logic          reqValid;
    logic          reqReady;
    logic          reqWrite;
    logic [31:0]   reqAddr;
    busPkg::sizeT  reqSize;
    busPkg::dataT  reqData;
    logic          respValid;
    logic          respReady;
    busPkg::dataT  respData;
    logic [31:0]   busAddr;
    busPkg::sizeT  busSize;
    logic          busRnW;
    logic          nAs;
    logic          nDs;
    busPkg::dataT  busDataOut;
    busPkg::dataT  busDataIn = '0;
    busPkg::dsackT nDsack = 2'b11;

    logic [7:0]    mem [256];
    busPkg::dsackT curDsack;
    int            curWaits;
    busPkg::dataT  curData;
    logic [31:0]   startAddr;
    logic [31:0]   expAddr;
    int            opLen;
    int            expRem;
    int            waitLeft;
    logic          strobed = 1'b0;
    logic          acked = 1'b0;
    int            reqSent;

    logic          trWrite [$];
    logic [31:0]   trAddr [$];
    busPkg::sizeT  trSize [$];
    busPkg::dataT  trData [$];
    busPkg::dsackT trDsack [$];
    int            trWaits [$];
    busPkg::dataT  trExp [$];

    bus68020Top u_bus68020Top (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic checkData(input string name, input busPkg::dataT got, input busPkg::dataT exp);
        if (got !== exp) begin
            failRun($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkSize(input string name, input busPkg::sizeT got, input busPkg::sizeT exp);
        if (got !== exp) begin
            failRun($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic checkAddr(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // Bytes a port takes in one cycle within its width and offset
    function automatic int portBytes(int remaining, busPkg::dsackT ack, logic [1:0] low);
        int room;
        case (ack)
            2'b00: room = 4 - low;
            2'b01: room = 2 - low[0];
            default: room = 1;
        endcase
        return (remaining < room) ? remaining : room;
    endfunction

    // Moves the bytes of one acknowledged cycle between lanes and memory
    task automatic answerCycle();
        busPkg::dataT word;
        busPkg::dataT lanes;
        busPkg::dataT mask;
        logic [31:0]  a;
        int           base;
        int           bitPos;
        int           moved;
        word = 32'he7e7e7e7;    // Filler on lanes the port leaves alone
        lanes = '0;
        mask = '0;
        moved = portBytes(expRem, curDsack, expAddr[1:0]);
        case (curDsack)
            2'b00: base = expAddr[1:0];
            2'b01: base = expAddr[0];
            default: base = 0;    // D31-D24 only
        endcase
        for (int j = 0; j < moved; j++) begin
            a = expAddr + j;
            bitPos = 8 * (3 - base - j);
            if (busRnW) begin
                word[bitPos +: 8] = mem[a[7:0]];
            end else begin
                lanes[bitPos +: 8] = curData[8 * (opLen - 1 - int'(a - startAddr)) +: 8];
                mask[bitPos +: 8] = 8'hff;
                mem[a[7:0]] = busDataOut[bitPos +: 8];
            end
        end
        if (!busRnW) begin
            checkData("busDataOut", busDataOut & mask, lanes);
        end
        nDsack <= curDsack;
        busDataIn <= word;
        expAddr = expAddr + moved;
        expRem = expRem - moved;
    endtask

    // Slave port that holds DSACK for one cycle after the programmed waits
    always @(posedge CLK) begin
        if (acked) begin
            nDsack <= 2'b11;
            acked = 1'b0;
            strobed = 1'b0;
        end else if (!nAs) begin
            if (nDs !== 1'b0) begin
                failRun($sformatf("Mismatch at %0t: nDs is %b, expected 0", $time, nDs));
            end
            if (!strobed) begin
                checkAddr("busAddr", busAddr, expAddr);
                checkSize("busSize", busSize, expRem[1:0]);
                strobed = 1'b1;
                waitLeft = curWaits;
            end
            if (waitLeft == 0) begin
                answerCycle();
                acked = 1'b1;
            end else begin
                waitLeft--;
            end
        end else if (strobed) begin
            failRun("Strobes went high before the cycle was acknowledged");
        end
    end

    // Puts one trace request on the requester port
    task automatic driveRequest(input int idx);
        reqValid <= 1'b1;
        reqWrite <= trWrite[idx];
        reqAddr <= trAddr[idx];
        reqSize <= trSize[idx];
        reqData <= trData[idx];
    endtask

    task automatic sendRequest(input int idx);
        int cycles;
        driveRequest(idx);
        cycles = 0;
        do begin
            @(posedge CLK);
            cycles++;
            if (cycles > 100) begin
                failRun("Request was not accepted within 100 cycles");
            end
        end while (!reqReady);
        reqValid <= 1'b0;
        reqSent++;
    endtask

    // Expected bus cycles of one operand for the slave model
    task automatic armSlave(input int idx);
        curDsack = trDsack[idx];
        curWaits = trWaits[idx];
        curData = trData[idx];
        startAddr = trAddr[idx];
        expAddr = trAddr[idx];
        opLen = (trSize[idx] == 2'b00) ? 4 : trSize[idx];
        expRem = opLen;
    endtask

    task automatic runTransaction(input int idx);
        int           cycles;
        logic         stalled;
        busPkg::dataT heldResp;
        armSlave(idx);
        stalled = 1'b0;
        heldResp = '0;
        if (reqSent == idx) begin
            sendRequest(idx);
        end
        cycles = 0;
        forever begin
            @(posedge CLK);
            cycles++;
            if (reqValid && reqReady) begin
                reqValid <= 1'b0;
                reqSent++;
            end
            if (respValid) begin
                if (stalled) begin
                    checkData("respData", respData, heldResp);    // Held through the stall
                end
                if (!nAs) begin
                    failRun($sformatf("Mismatch at %0t: nAs is 0, expected 1", $time));
                end
                if (nDs !== 1'b1) begin
                    failRun($sformatf("Mismatch at %0t: nDs is %b, expected 1", $time, nDs));
                end
                if (respReady) begin
                    break;
                end
                stalled = 1'b1;
                heldResp = respData;
                if (!reqValid && reqSent == idx + 1 && reqSent < trAddr.size()) begin
                    driveRequest(reqSent);    // Next operand waits behind the held response
                end
            end else if (stalled) begin
                failRun("respValid dropped before the response was accepted");
            end
            if (cycles > 300) begin
                failRun("No response within 300 cycles");
            end
            respReady <= ($urandom % 4) == 0;
        end
        respReady <= 1'b0;
        if (expRem != 0) begin
            failRun("Response arrived before all operand bytes were moved");
        end
        checkData("respData", respData, trExp[idx]);
    endtask

    initial begin
        int           fd;
        int           op;
        int           sizeCode;
        int           dsackCode;
        int           waits;
        logic [31:0]  addr;
        busPkg::dataT data;
        busPkg::dataT expected;
        string        line;
        void'($urandom(32'hdb67025d));
        for (int a = 0; a < 256; a++) begin
            mem[a] = a[7:0] ^ 8'h5a;
        end
        in_RESET = 1'b0;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        reqSize = '0;
        reqData = '0;
        respReady = 1'b0;
        reqSent = 0;
        repeat (16) @(posedge CLK);
        in_RESET <= 1'b1;
        @(posedge CLK);
        if (respValid !== 1'b0 || nAs !== 1'b1 || nDs !== 1'b1 || busRnW !== 1'b1) begin
            failRun($sformatf(
                "Mismatch at %0t: respValid nAs nDs busRnW are %b %b %b %b, expected 0 1 1 1",
                $time, respValid, nAs, nDs, busRnW));
        end
        fd = $fopen("tb/busTrace.txt", "r");
        if (fd == 0) begin
            failRun("Could not open tb/busTrace.txt");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if ($sscanf(line, "%h %h %h %h %h %d %h", op, addr, sizeCode, data, dsackCode,
                        waits, expected) == 7) begin
                trWrite.push_back(op[0]);
                trAddr.push_back(addr);
                trSize.push_back(sizeCode[1:0]);
                trData.push_back(data);
                trDsack.push_back(dsackCode[1:0]);
                trWaits.push_back(waits);
                trExp.push_back(expected);
            end
        end
        $fclose(fd);
        for (int i = 0; i < trAddr.size(); i++) begin
            runTransaction(i);
        end
        if (trAddr.size() == 0) begin
            failRun("Trace file held no transactions");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

/* design/bus68020Top.sv */
// Top of the 68020-style bus master
// Joins request entry, cycle FSM, read assembly and write steering
module bus68020Top #(
    parameter int addrWidth = 32
) (
    input  logic                 CLK,
    input  logic                 in_RESET,
    input  logic                 reqValid,
    output logic                 reqReady,
    input  logic                 reqWrite,
    input  logic [addrWidth-1:0] reqAddr,
    input  busPkg::sizeT         reqSize,
    input  busPkg::dataT         reqData,
    output logic                 respValid,
    input  logic                 respReady,
    output busPkg::dataT         respData,
    output logic [addrWidth-1:0] busAddr,
    output busPkg::sizeT         busSize,
    output logic                 busRnW,
    output logic                 nAs,
    output logic                 nDs,
    output busPkg::dataT         busDataOut,
    input  busPkg::dataT         busDataIn,
    input  busPkg::dsackT        nDsack
);

    logic                 heldValid;
    logic                 heldWrite;
    logic [addrWidth-1:0] heldAddr;
    busPkg::sizeT         heldSize;
    busPkg::dataT         heldData;
    logic                 take;
    logic                 respBusy;
    logic                 beatDone;
    busPkg::dsackT        beatDsack;
    logic [1:0]           beatAddrLow;
    busPkg::sizeT         beatSize;
    logic                 opStart;
    busPkg::sizeT         opSize;
    logic                 opLast;

    busRequestStage #(.addrWidth(addrWidth)) u_busRequestStage (
        .CLK(CLK),
        .in_RESET(in_RESET),
        .reqValid(reqValid),
        .reqWrite(reqWrite),
        .reqAddr(reqAddr),
        .reqSize(reqSize),
        .reqData(reqData),
        .take(take),
        .reqReady(reqReady),
        .heldValid(heldValid),
        .heldWrite(heldWrite),
        .heldAddr(heldAddr),
        .heldSize(heldSize),
        .heldData(heldData)
    );

    busCycleSequencer #(.addrWidth(addrWidth)) u_busCycleSequencer (
        .CLK(CLK),
        .in_RESET(in_RESET),
        .heldValid(heldValid),
        .heldWrite(heldWrite),
        .heldAddr(heldAddr),
        .heldSize(heldSize),
        .respBusy(respBusy),
        .nDsack(nDsack),
        .take(take),
        .busAddr(busAddr),
        .busSize(busSize),
        .busRnW(busRnW),
        .nAs(nAs),
        .nDs(nDs),
        .beatDone(beatDone),
        .beatDsack(beatDsack),
        .beatAddrLow(beatAddrLow),
        .beatSize(beatSize),
        .opStart(opStart),
        .opSize(opSize),
        .opLast(opLast)
    );

    readLaneAssembler u_readLaneAssembler (
        .CLK(CLK),
        .in_RESET(in_RESET),
        .beatDone(beatDone),
        .beatDsack(beatDsack),
        .beatAddrLow(beatAddrLow),
        .beatSize(beatSize),
        .opStart(opStart),
        .opSize(opSize),
        .opLast(opLast),
        .heldWrite(heldWrite),
        .busDataIn(busDataIn),
        .respReady(respReady),
        .respValid(respValid),
        .respData(respData),
        .respBusy(respBusy)
    );

    writeLaneDriver u_writeLaneDriver (
        .beatSize(beatSize),
        .beatAddrLow(beatAddrLow),
        .heldData(heldData),
        .busDataOut(busDataOut)
    );

endmodule

/* design/writeLaneDriver.sv */
// Write lane steering for the bus master
// Replicates the remaining operand bytes so every port width sees its data
module writeLaneDriver (
    input  busPkg::sizeT beatSize,
    input  logic [1:0]   beatAddrLow,
    input  busPkg::dataT heldData,
    output busPkg::dataT busDataOut
);

    busPkg::dataT aligned;
    logic [2:0]   skipBytes;

    // Remaining bytes moved up so the next one sits in aligned[31:24]
    assign skipBytes = 3'd4 - busPkg::byteCount(beatSize);
    assign aligned = heldData << {skipBytes, 3'b000};

    always_comb begin
        case (beatAddrLow)
            2'b00: busDataOut = aligned;
            2'b01: busDataOut = {aligned[31:24], aligned[31:8]};
            2'b10: busDataOut = {aligned[31:16], aligned[31:16]};
            default: busDataOut = {aligned[31:24], aligned[31:24],
                                   aligned[23:16], aligned[31:24]};
        endcase
    end

endmodule

/* design/readLaneAssembler.sv */
// Read assembly and response holding for the bus master
// Copies acknowledged lanes into the operand, MSB first
module readLaneAssembler (
    input  logic          CLK,
    input  logic          in_RESET,
    input  logic          beatDone,
    input  busPkg::dsackT beatDsack,
    input  logic [1:0]    beatAddrLow,
    input  busPkg::sizeT  beatSize,
    input  logic          opStart,
    input  busPkg::sizeT  opSize,
    input  logic          opLast,
    input  logic          heldWrite,
    input  busPkg::dataT  busDataIn,
    input  logic          respReady,
    output logic          respValid,
    output busPkg::dataT  respData,
    output logic          respBusy
);

    logic [2:0]   opLen;
    logic [2:0]   filled;
    logic [2:0]   beatCount;
    logic [1:0]   firstLane;
    busPkg::dataT assembled;

    assign beatCount = busPkg::beatBytes(busPkg::byteCount(beatSize), beatDsack, beatAddrLow);
    assign respBusy = respValid;

    always_comb begin
        case (beatDsack)
            busPkg::dsackPort32: firstLane = beatAddrLow;
            busPkg::dsackPort16: firstLane = {1'b0, beatAddrLow[0]};
            default: firstLane = 2'd0;          // D31-D24 only
        endcase
    end

    // Lane 0 is D31-D24; operand byte 0 is the lowest one
    always_comb begin
        int pos;
        int lane;
        assembled = respData;
        for (int j = 0; j < 4; j++) begin
            pos = int'(opLen) - 1 - int'(filled) - j;
            lane = int'(firstLane) + j;
            if (j < int'(beatCount) && pos >= 0 && lane < 4) begin
                assembled[8*pos +: 8] = busDataIn[8*(3-lane) +: 8];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            respValid <= 1'b0;
            filled <= 3'd0;
        end else begin
            if (opStart) begin
                filled <= 3'd0;
            end else if (beatDone) begin
                filled <= filled + beatCount;
            end
            if (beatDone && opLast) begin
                respValid <= 1'b1;
            end else if (respValid && respReady) begin
                respValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (opStart) begin
            opLen <= busPkg::byteCount(opSize);
            respData <= '0;
        end else if (beatDone) begin
            respData <= heldWrite ? '0 : assembled;   // Writes answer with zero
        end
    end

endmodule

/* design/busCycleSequencer.sv */
// Bus cycle FSM of the 68020-style master
// Splits an operand into sized cycles following the port width in DSACK
module busCycleSequencer #(
    parameter int addrWidth = 32
) (
    input  logic                 CLK,
    input  logic                 in_RESET,
    input  logic                 heldValid,
    input  logic                 heldWrite,
    input  logic [addrWidth-1:0] heldAddr,
    input  busPkg::sizeT         heldSize,
    input  logic                 respBusy,
    input  busPkg::dsackT        nDsack,
    output logic                 take,
    output logic [addrWidth-1:0] busAddr,
    output busPkg::sizeT         busSize,
    output logic                 busRnW,
    output logic                 nAs,
    output logic                 nDs,
    output logic                 beatDone,
    output busPkg::dsackT        beatDsack,
    output logic [1:0]           beatAddrLow,
    output busPkg::sizeT         beatSize,
    output logic                 opStart,
    output busPkg::sizeT         opSize,
    output logic                 opLast
);

    localparam logic [2:0] stIdle = 3'd0;
    localparam logic [2:0] stS0 = 3'd1;
    localparam logic [2:0] stStrobe = 3'd2;
    localparam logic [2:0] stWaitAck = 3'd3;
    localparam logic [2:0] stNegate = 3'd4;

    logic [2:0]           state;
    logic [addrWidth-1:0] runAddr;
    logic [2:0]           remBytes;
    logic [2:0]           beatCount;
    logic                 ackCycle;
    logic                 startOp;

    assign ackCycle = (state == stStrobe) || (state == stWaitAck);
    assign startOp = (state == stIdle) && heldValid && !respBusy;
    assign beatCount = busPkg::beatBytes(remBytes, nDsack, runAddr[1:0]);

    assign beatDone = ackCycle && (nDsack != busPkg::dsackWait);
    assign opLast = beatDone && (beatCount == remBytes);
    assign take = opLast;            // Entry frees on the last cycle
    assign opStart = startOp;
    assign opSize = heldSize;

    assign beatDsack = nDsack;
    assign beatAddrLow = runAddr[1:0];
    assign beatSize = remBytes[1:0];   // A count of 4 wraps to the long code

    assign busAddr = runAddr;
    assign busSize = remBytes[1:0];
    assign nAs = ~ackCycle;
    assign nDs = ~ackCycle;

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            state <= stIdle;
            busRnW <= 1'b1;
            runAddr <= '0;
            remBytes <= 3'd0;
        end else begin
            case (state)
                stIdle: begin
                    if (startOp) begin
                        state <= stS0;
                        busRnW <= ~heldWrite;
                        runAddr <= heldAddr;
                        remBytes <= busPkg::byteCount(heldSize);
                    end
                end
                stS0: state <= stStrobe;
                stStrobe, stWaitAck: begin
                    if (beatDone) begin
                        state <= stNegate;
                        runAddr <= runAddr + {{(addrWidth-3){1'b0}}, beatCount};
                        remBytes <= remBytes - beatCount;
                    end else begin
                        state <= stWaitAck;
                    end
                end
                stNegate: begin
                    if (remBytes == 3'd0) begin
                        state <= stIdle;
                        busRnW <= 1'b1;
                    end else begin
                        state <= stS0;        // Next piece of the operand
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

/* design/busRequestStage.sv */
// Request entry of the bus master
// Holds one operand request until its last bus cycle completes
module busRequestStage #(
    parameter int addrWidth = 32
) (
    input  logic                 CLK,
    input  logic                 in_RESET,
    input  logic                 reqValid,
    input  logic                 reqWrite,
    input  logic [addrWidth-1:0] reqAddr,
    input  busPkg::sizeT         reqSize,
    input  busPkg::dataT         reqData,
    input  logic                 take,
    output logic                 reqReady,
    output logic                 heldValid,
    output logic                 heldWrite,
    output logic [addrWidth-1:0] heldAddr,
    output busPkg::sizeT         heldSize,
    output busPkg::dataT         heldData
);

    assign reqReady = ~heldValid;    // Free again the cycle after take

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            heldValid <= 1'b0;
        end else if (reqValid && reqReady) begin
            heldValid <= 1'b1;
        end else if (take) begin
            heldValid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (reqValid && reqReady) begin
            heldWrite <= reqWrite;
            heldAddr <= reqAddr;
            heldSize <= reqSize;
            heldData <= reqData;    // Stays put while the operand runs
        end
    end

endmodule

/* design/busPkg.sv */
// Shared codes and helpers for the 68020-style bus master
// SIZ and DSACK values follow the pin encodings of the bus
package busPkg;

    typedef logic [1:0] sizeT;     // SIZ1:SIZ0, 00 is a long
    typedef logic [1:0] dsackT;    // DSACK1:DSACK0, active low
    typedef logic [31:0] dataT;

    localparam sizeT sizeLong = 2'b00;

    localparam dsackT dsackPort32 = 2'b00;
    localparam dsackT dsackPort16 = 2'b01;
    localparam dsackT dsackWait = 2'b11;

    function automatic logic [2:0] byteCount(sizeT size);
        return (size == sizeLong) ? 3'd4 : {1'b0, size};
    endfunction

    // Bytes a single bus cycle moves for the given port and offset
    function automatic logic [2:0] beatBytes(
        logic [2:0] remaining,
        dsackT ack,
        logic [1:0] addrLow
    );
        logic [2:0] room;
        case (ack)
            dsackPort32: room = 3'd4 - {1'b0, addrLow};
            dsackPort16: room = 3'd2 - {2'b00, addrLow[0]};
            default: room = 3'd1;                  // 8-bit port
        endcase
        return (remaining < room) ? remaining : room;
    endfunction

endpackage
